// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_mat_decd
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/mat_cal_decoder.sv ====
// combinational decoder for calculation-class matrix instructions, feeds the merge stage
module mat_cal_decoder (
    input  logic [mat_decd_pkg::OPCODE_W-1:0] inst_opcode,
    input  mat_decd_pkg::mat_type_t           inst_type,
    output mat_decd_pkg::alu_meta_t           cal_meta,
    output logic                              cal_hit
);

    mat_decd_pkg::func_t   func;
    mat_decd_pkg::uop_t    uop;
    logic                  size;
    mat_decd_pkg::uimm3_t  uimm3;
    mat_decd_pkg::cal_op_t arith_op; // pointwise ops, func 0011..1001
    mat_decd_pkg::cal_op_t op;

    assign func  = inst_opcode[mat_decd_pkg::FUNC_MSB:mat_decd_pkg::FUNC_LSB];
    assign uop   = inst_opcode[mat_decd_pkg::UOP_MSB:mat_decd_pkg::UOP_LSB];
    assign size  = inst_opcode[mat_decd_pkg::SIZE_BIT];
    assign uimm3 = inst_opcode[mat_decd_pkg::UIMM3_LSB +: mat_decd_pkg::UIMM3_W];

    always_comb
    begin
        case (func)
            mat_decd_pkg::FUNC_MADD:     arith_op = mat_decd_pkg::CAL_MADD;
            mat_decd_pkg::FUNC_MSUB:     arith_op = mat_decd_pkg::CAL_MSUB;
            mat_decd_pkg::FUNC_MSRA:     arith_op = mat_decd_pkg::CAL_MSRA;
            mat_decd_pkg::FUNC_MN4CLIP:  arith_op = mat_decd_pkg::CAL_MN4CLIP;
            mat_decd_pkg::FUNC_MN4CLIPU: arith_op = mat_decd_pkg::CAL_MN4CLIPU;
            mat_decd_pkg::FUNC_MMUL:     arith_op = mat_decd_pkg::CAL_MMUL;
            mat_decd_pkg::FUNC_MMULH:    arith_op = mat_decd_pkg::CAL_MMULH;
            default:                     arith_op = '0;
        endcase
    end

    always_comb
    begin
        op      = '0;
        cal_hit = 1'b0;
        if (inst_type == mat_decd_pkg::MAT_CAL)
        begin
            case (func)
                mat_decd_pkg::FUNC_MMOV:
                begin
                    // mm, mv.x and mv.i only
                    if (!size && uop inside {mat_decd_pkg::UOP_MM, mat_decd_pkg::UOP_MV_X,
                                             mat_decd_pkg::UOP_MV_I})
                    begin
                        op      = mat_decd_pkg::CAL_MMOV;
                        cal_hit = 1'b1;
                    end
                end
                mat_decd_pkg::FUNC_FMMACC:
                begin
                    if (uop == mat_decd_pkg::UOP_MM)
                    begin
                        op      = size ? mat_decd_pkg::CAL_FWMMACC : mat_decd_pkg::CAL_FMMACC;
                        cal_hit = 1'b1;
                    end
                end
                mat_decd_pkg::FUNC_MMAQA:
                begin
                    if (!size && uop == mat_decd_pkg::UOP_MM)
                    begin
                        op      = mat_decd_pkg::CAL_MMAQA;
                        cal_hit = 1'b1;
                    end
                end
                default:
                begin
                    if (!size && arith_op != '0 &&
                        uop inside {mat_decd_pkg::UOP_MM, mat_decd_pkg::UOP_MV_X,
                                    mat_decd_pkg::UOP_MV_I, mat_decd_pkg::UOP_MX})
                    begin
                        op      = arith_op;
                        cal_hit = 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb
    begin
        cal_meta            = '0;
        cal_meta.op         = op;
        cal_meta.dstm_idx   = inst_opcode[mat_decd_pkg::DSTM_ARITH_LSB +: mat_decd_pkg::REG_IDX_W];
        cal_meta.src1m_idx  = inst_opcode[mat_decd_pkg::SRCM1_LSB +: mat_decd_pkg::REG_IDX_W];
        cal_meta.src0m_idx  = inst_opcode[mat_decd_pkg::SRCM0_LSB +: mat_decd_pkg::REG_IDX_W];
        cal_meta.uimm3      = uimm3;
        cal_meta.elem_width = inst_opcode[mat_decd_pkg::ELEM_LSB +: mat_decd_pkg::ELEM_W];

        // only mmaqa consumes these, later stages ignore them otherwise
        case (uimm3)
            mat_decd_pkg::SGN_UU:
            begin
                cal_meta.src0m_unsigned = 1'b1;
                cal_meta.src1m_unsigned = 1'b1;
            end
            mat_decd_pkg::SGN_US:
            begin
                cal_meta.src0m_unsigned = 1'b1;
                cal_meta.src1m_unsigned = 1'b0;
            end
            mat_decd_pkg::SGN_SU:
            begin
                cal_meta.src0m_unsigned = 1'b0;
                cal_meta.src1m_unsigned = 1'b1;
            end
            default: // SGN_SS and 1xx
            begin
                cal_meta.src0m_unsigned = 1'b0;
                cal_meta.src1m_unsigned = 1'b0;
            end
        endcase

        if (cal_hit)
        begin
            cal_meta.dstm_vld  = 1'b1;
            cal_meta.src1m_vld = (op != mat_decd_pkg::CAL_MMOV);   // mmov has one source
            cal_meta.src0m_vld = (uop != mat_decd_pkg::UOP_MX);    // mx takes src0 from gpr
            cal_meta.uimm3_vld = (uop == mat_decd_pkg::UOP_MV_I);
        end
    end

    // every matching row names exactly one operation
    always_comb
    begin
        if (cal_hit)
            assert ($onehot(cal_meta.op)) else $error("cal op not one-hot on a hit");
    end

endmodule

// ==== design/mat_decd_pkg.sv ====
// shared widths, encodings, opcode field positions and metadata records, used by every decode file
package mat_decd_pkg;

    localparam int OPCODE_W  = 32;
    localparam int TYPE_W    = 4;
    localparam int REG_IDX_W = 3;
    localparam int ELEM_W    = 2;
    localparam int NF_W      = 3;
    localparam int UIMM3_W   = 3;
    localparam int UIMM7_W   = 7;
    localparam int CAL_OP_W  = 11;
    localparam int LSU_OP_W  = 2;
    localparam int CFG_OP_W  = 4;

    typedef logic [TYPE_W-1:0]    mat_type_t;    // one-hot instruction class
    typedef logic [REG_IDX_W-1:0] mat_reg_idx_t;
    typedef logic [ELEM_W-1:0]    elem_width_t;  // 00/01/10/11 -> 8/16/32/64
    typedef logic [NF_W-1:0]      nf_t;          // 000/001/011/111 -> 1/2/4/8 regs
    typedef logic [UIMM3_W-1:0]   uimm3_t;
    typedef logic [UIMM7_W-1:0]   uimm7_t;
    typedef logic [CAL_OP_W-1:0]  cal_op_t;
    typedef logic [LSU_OP_W-1:0]  lsu_op_t;
    typedef logic [CFG_OP_W-1:0]  cfg_op_t;

    // instruction classes
    localparam mat_type_t MAT_CAL         = 4'b0001;
    localparam mat_type_t MAT_LSU         = 4'b0010;
    localparam mat_type_t MAT_CFG         = 4'b0100;
    localparam mat_type_t MAT_SPECIAL_MOV = 4'b1000; // no decode rows, always illegal

    // calculation ops, one-hot
    localparam cal_op_t CAL_MMOV     = 11'b000_0000_0001;
    localparam cal_op_t CAL_FMMACC   = 11'b000_0000_0010;
    localparam cal_op_t CAL_FWMMACC  = 11'b000_0000_0100;
    localparam cal_op_t CAL_MMAQA    = 11'b000_0000_1000;
    localparam cal_op_t CAL_MADD     = 11'b000_0001_0000;
    localparam cal_op_t CAL_MSUB     = 11'b000_0010_0000;
    localparam cal_op_t CAL_MSRA     = 11'b000_0100_0000;
    localparam cal_op_t CAL_MN4CLIP  = 11'b000_1000_0000; // signed clip
    localparam cal_op_t CAL_MN4CLIPU = 11'b001_0000_0000; // unsigned clip
    localparam cal_op_t CAL_MMUL     = 11'b010_0000_0000;
    localparam cal_op_t CAL_MMULH    = 11'b100_0000_0000;

    localparam lsu_op_t LSU_LOAD  = 2'b01;
    localparam lsu_op_t LSU_STORE = 2'b10;

    localparam cfg_op_t CFG_K   = 4'b0001;
    localparam cfg_op_t CFG_M   = 4'b0010;
    localparam cfg_op_t CFG_N   = 4'b0100;
    localparam cfg_op_t CFG_ALL = 4'b1000;

    // opcode field positions
    localparam int FUNC_MSB       = 31;
    localparam int FUNC_LSB       = 28;
    localparam int UOP_MSB        = 27;
    localparam int UOP_LSB        = 25;
    localparam int SIZE_BIT       = 24;
    localparam int DSTM_ARITH_LSB = 15; // md of arithmetic ops
    localparam int DSTM_MEM_LSB   = 7;  // md of loads
    localparam int SRCM0_LSB      = 18;
    localparam int SRCM1_LSB      = 21;
    localparam int SRCM2_LSB      = 7;  // ms3 of stores
    localparam int UIMM3_LSB      = 7;
    localparam int NF_LSB         = 20;
    localparam int ELEM_LSB       = 10;
    localparam int UIMM7_LSB      = 18;

    typedef logic [FUNC_MSB-FUNC_LSB:0] func_t;
    typedef logic [UOP_MSB-UOP_LSB:0]   uop_t;

    // func codes
    localparam func_t FUNC_MMOV      = 4'b0000;
    localparam func_t FUNC_FMMACC    = 4'b0001; // size picks the widening form
    localparam func_t FUNC_MMAQA     = 4'b0010;
    localparam func_t FUNC_MADD      = 4'b0011;
    localparam func_t FUNC_MSUB      = 4'b0100;
    localparam func_t FUNC_MSRA      = 4'b0101;
    localparam func_t FUNC_MN4CLIP   = 4'b0110;
    localparam func_t FUNC_MN4CLIPU  = 4'b0111;
    localparam func_t FUNC_MMUL      = 4'b1000;
    localparam func_t FUNC_MMULH     = 4'b1001;
    localparam func_t FUNC_LSU_ELEM  = 4'b0000;
    localparam func_t FUNC_LSU_WHOLE = 4'b0010;
    localparam func_t FUNC_CFG_ALL   = 4'b1111;

    // low func bits of mcfgk/m/n, top bit is don't care
    localparam logic [2:0] CFG_SEL_K = 3'b000;
    localparam logic [2:0] CFG_SEL_M = 3'b001;
    localparam logic [2:0] CFG_SEL_N = 3'b010;

    // uop forms
    localparam uop_t UOP_MM    = 3'b000;
    localparam uop_t UOP_MV_X  = 3'b001;
    localparam uop_t UOP_MV_I  = 3'b010;
    localparam uop_t UOP_MX    = 3'b011;
    localparam uop_t UOP_LOAD  = 3'b100;
    localparam uop_t UOP_STORE = 3'b101;
    localparam uop_t UOP_CFG   = 3'b111;

    // uimm3 reused as source signedness
    localparam uimm3_t SGN_SS = 3'b000; // both signed
    localparam uimm3_t SGN_UU = 3'b001; // both unsigned
    localparam uimm3_t SGN_US = 3'b010; // src0 unsigned
    localparam uimm3_t SGN_SU = 3'b011; // src1 unsigned

    typedef struct packed {
        cal_op_t      op;
        logic         dstm_vld;
        mat_reg_idx_t dstm_idx;
        logic         src1m_vld;
        logic         src1m_unsigned;
        mat_reg_idx_t src1m_idx;
        logic         src0m_vld;
        logic         src0m_unsigned;
        mat_reg_idx_t src0m_idx;
        logic         uimm3_vld;
        uimm3_t       uimm3;
        elem_width_t  elem_width;
    } alu_meta_t;

    typedef struct packed {
        lsu_op_t      op;
        logic         dstm_vld;
        mat_reg_idx_t dstm_idx;
        logic         src2m_vld;
        mat_reg_idx_t src2m_idx;
        logic         nf_vld;
        nf_t          nf;
        elem_width_t  elem_width;
    } lsu_meta_t;

    typedef struct packed {
        cfg_op_t op;
        uimm7_t  uimm7;
    } cfg_meta_t;

endpackage

// ==== design/mat_decd_stage.sv ====
// matrix decode pipe stage, two decoders side by side feeding one registered merge
module mat_decd_stage (
    input  logic                              cpuclk,
    input  logic                              arst_n,
    input  logic                              inst_vld,
    input  logic [mat_decd_pkg::OPCODE_W-1:0] inst_opcode,
    input  mat_decd_pkg::mat_type_t           inst_type,
    output mat_decd_pkg::alu_meta_t           alu_meta,
    output mat_decd_pkg::lsu_meta_t           lsu_meta,
    output mat_decd_pkg::cfg_meta_t           cfg_meta,
    output logic                              meta_vld,
    output logic                              decd_illegal
);

    mat_decd_pkg::alu_meta_t cal_meta;
    mat_decd_pkg::lsu_meta_t lsu_meta_dec; // unregistered lsu record
    mat_decd_pkg::cfg_meta_t cfg_meta_raw;
    logic                    cal_hit;
    logic                    lsu_hit;
    logic                    cfg_hit;

    mat_cal_decoder cal_dec_i (
        .inst_opcode (inst_opcode),
        .inst_type   (inst_type),
        .cal_meta    (cal_meta),
        .cal_hit     (cal_hit)
    );

    mat_mem_cfg_decoder mem_cfg_dec_i (
        .inst_opcode  (inst_opcode),
        .inst_type    (inst_type),
        .lsu_meta     (lsu_meta_dec),
        .cfg_meta_raw (cfg_meta_raw),
        .lsu_hit      (lsu_hit),
        .cfg_hit      (cfg_hit)
    );

    mat_meta_merge merge_i (
        .cpuclk       (cpuclk),
        .arst_n       (arst_n),
        .inst_vld     (inst_vld),
        .cal_hit      (cal_hit),
        .lsu_hit      (lsu_hit),
        .cfg_hit      (cfg_hit),
        .cal_meta     (cal_meta),
        .lsu_meta     (lsu_meta_dec),
        .cfg_meta_raw (cfg_meta_raw),
        .alu_meta     (alu_meta),
        .lsu_meta_q   (lsu_meta),
        .cfg_meta     (cfg_meta),
        .meta_vld     (meta_vld),
        .decd_illegal (decd_illegal)
    );

endmodule

// ==== design/mat_mem_cfg_decoder.sv ====
// combinational decoder for matrix load/store and configuration instructions
module mat_mem_cfg_decoder (
    input  logic [mat_decd_pkg::OPCODE_W-1:0] inst_opcode,
    input  mat_decd_pkg::mat_type_t           inst_type,
    output mat_decd_pkg::lsu_meta_t           lsu_meta,
    output mat_decd_pkg::cfg_meta_t           cfg_meta_raw,
    output logic                              lsu_hit,
    output logic                              cfg_hit
);

    mat_decd_pkg::func_t func;
    mat_decd_pkg::uop_t  uop;
    logic                size;
    logic                is_load;
    logic                is_store;

    assign func     = inst_opcode[mat_decd_pkg::FUNC_MSB:mat_decd_pkg::FUNC_LSB];
    assign uop      = inst_opcode[mat_decd_pkg::UOP_MSB:mat_decd_pkg::UOP_LSB];
    assign size     = inst_opcode[mat_decd_pkg::SIZE_BIT];
    assign is_load  = (uop == mat_decd_pkg::UOP_LOAD);
    assign is_store = (uop == mat_decd_pkg::UOP_STORE);

    always_comb
    begin
        lsu_meta            = '0;
        lsu_meta.dstm_idx   = inst_opcode[mat_decd_pkg::DSTM_MEM_LSB +: mat_decd_pkg::REG_IDX_W];
        lsu_meta.src2m_idx  = inst_opcode[mat_decd_pkg::SRCM2_LSB +: mat_decd_pkg::REG_IDX_W];
        lsu_meta.nf         = inst_opcode[mat_decd_pkg::NF_LSB +: mat_decd_pkg::NF_W];
        lsu_meta.elem_width = inst_opcode[mat_decd_pkg::ELEM_LSB +: mat_decd_pkg::ELEM_W];
        lsu_hit             = 1'b0;
        if (inst_type == mat_decd_pkg::MAT_LSU && (is_load || is_store))
        begin
            if (func == mat_decd_pkg::FUNC_LSU_ELEM)
                lsu_hit = 1'b1; // element width picks the access, size ignored
            else if (func == mat_decd_pkg::FUNC_LSU_WHOLE && !size)
            begin
                lsu_hit         = 1'b1;
                lsu_meta.nf_vld = 1'b1; // whole-register group, count from nf
            end
        end
        if (lsu_hit)
        begin
            lsu_meta.op        = is_load ? mat_decd_pkg::LSU_LOAD : mat_decd_pkg::LSU_STORE;
            lsu_meta.dstm_vld  = is_load;
            lsu_meta.src2m_vld = is_store;
        end
    end

    always_comb
    begin
        cfg_meta_raw       = '0;
        cfg_meta_raw.uimm7 = inst_opcode[mat_decd_pkg::UIMM7_LSB +: mat_decd_pkg::UIMM7_W];
        cfg_hit            = 1'b0;
        if (inst_type == mat_decd_pkg::MAT_CFG && uop == mat_decd_pkg::UOP_CFG)
        begin
            if (func == mat_decd_pkg::FUNC_CFG_ALL)
            begin
                cfg_meta_raw.op = size ? '0 : mat_decd_pkg::CFG_ALL; // mcfg only with size 0
            end
            else
            begin
                case (func[2:0])
                    mat_decd_pkg::CFG_SEL_K: cfg_meta_raw.op = mat_decd_pkg::CFG_K;
                    mat_decd_pkg::CFG_SEL_M: cfg_meta_raw.op = mat_decd_pkg::CFG_M;
                    mat_decd_pkg::CFG_SEL_N: cfg_meta_raw.op = mat_decd_pkg::CFG_N;
                    default:                 cfg_meta_raw.op = '0;
                endcase
            end
            cfg_hit = (cfg_meta_raw.op != '0);
        end
    end

    // lsu and cfg rows sit in different classes
    always_comb
    begin
        assert (!(lsu_hit && cfg_hit)) else $error("lsu and cfg hit together");
    end

endmodule

// ==== design/mat_meta_merge.sv ====
// merges both decoder results, flags illegal instructions and registers the stage outputs
module mat_meta_merge (
    input  logic                    cpuclk,
    input  logic                    arst_n,
    input  logic                    inst_vld,
    input  logic                    cal_hit,
    input  logic                    lsu_hit,
    input  logic                    cfg_hit,
    input  mat_decd_pkg::alu_meta_t cal_meta,
    input  mat_decd_pkg::lsu_meta_t lsu_meta,
    input  mat_decd_pkg::cfg_meta_t cfg_meta_raw,
    output mat_decd_pkg::alu_meta_t alu_meta,
    output mat_decd_pkg::lsu_meta_t lsu_meta_q,
    output mat_decd_pkg::cfg_meta_t cfg_meta,
    output logic                    meta_vld,
    output logic                    decd_illegal
);

    mat_decd_pkg::alu_meta_t alu_meta_d;
    mat_decd_pkg::lsu_meta_t lsu_meta_d;
    mat_decd_pkg::cfg_meta_t cfg_meta_d;
    logic                    illegal_d;

    // records of a decoder that did not match go out as zero
    assign alu_meta_d = cal_hit ? cal_meta : '0;
    assign lsu_meta_d = lsu_hit ? lsu_meta : '0;
    assign cfg_meta_d = cfg_hit ? cfg_meta_raw : '0;
    assign illegal_d  = !(cal_hit || lsu_hit || cfg_hit); // includes special move

    always_ff @(posedge cpuclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            meta_vld     <= 1'b0;
            decd_illegal <= 1'b0;
            alu_meta     <= '0;
            lsu_meta_q   <= '0;
            cfg_meta     <= '0;
        end
        else
        begin
            meta_vld     <= inst_vld;              // one-cycle strobe
            decd_illegal <= inst_vld && illegal_d; // only with meta_vld
            if (inst_vld)
            begin
                alu_meta   <= alu_meta_d;
                lsu_meta_q <= lsu_meta_d;
                cfg_meta   <= cfg_meta_d;
            end
        end
    end

    // the two decoders never claim the same opcode
    assert property (@(posedge cpuclk) disable iff (!arst_n)
        $onehot0({cal_hit, lsu_hit, cfg_hit}));

    // illegal result comes as a strobe with all records cleared
    assert property (@(posedge cpuclk) disable iff (!arst_n)
        decd_illegal |-> meta_vld && alu_meta == '0 && lsu_meta_q == '0 && cfg_meta == '0);

endmodule

// ==== dv/mat_decd_cases.txt ====
// tag type opcode alu_meta lsu_meta cfg_meta illegal idle, all hex
// idle is the number of quiet cycles driven before the instruction
01 1 00298800 001B0C82 0000 000 0 0
03 1 04298800 001B0CA2 0000 000 0 0
04 1 10298800 002B8C82 0000 000 0 0
05 1 11298800 004B8C82 0000 000 0 1
06 1 20298800 008B8C82 0000 000 0 0
07 1 30298800 010B8C82 0000 000 0 0
08 1 42298800 020B8C82 0000 000 0 0
09 1 54298800 040B8CA2 0000 000 0 0
0a 1 66298800 080B8882 0000 000 0 0
0b 1 70298800 100B8C82 0000 000 0 2
0c 1 84298800 200B8CA2 0000 000 0 0
0d 1 96298800 400B8882 0000 000 0 0
10 1 20298880 008BCE86 0000 000 0 0
11 1 20298900 008B8E8A 0000 000 0 0
12 1 20298980 008BCC8E 0000 000 0 0
13 1 20298B00 008B8C9A 0000 000 0 1
14 2 08300E80 00000000 754F 000 0 0
15 2 0B300E80 00000000 974F 000 0 0
16 2 28300E80 00000000 756F 000 0 0
17 2 2A300E80 00000000 976F 000 0 0
18 2 29300E80 00000000 0000 000 1 0
19 2 08700080 00000000 645C 000 0 1
1a 4 0E540000 00000000 0000 095 0 0
1b 4 9FA80000 00000000 0000 16A 0 0
1c 4 2FFC0000 00000000 0000 27F 0 0
1d 4 FEF00000 00000000 0000 43C 0 0
1e 4 FF040000 00000000 0000 000 1 0
1f 4 3E000000 00000000 0000 000 1 0
20 4 00540000 00000000 0000 000 1 1
21 8 00298800 00000000 0000 000 1 0
22 0 30298800 00000000 0000 000 1 0
23 1 A0298800 00000000 0000 000 1 0
24 1 06298800 00000000 0000 000 1 0
26 1 22298800 00000000 0000 000 1 0
27 1 31298800 00000000 0000 000 1 0
29 2 30298800 00000000 0000 000 1 0
2a 1 30298800 010B8C82 0000 000 0 0

// ==== dv/tb_mat_decd.sv ====
// testbench for the matrix decode stage, replays the cases file and checks every registered result
module tb_mat_decd;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int RESET_TIME   = CLK_PERIOD * RESET_CYCLES;
    localparam int CASE_TIME    = 40; // watchdog budget per case

    typedef struct packed {
        logic [7:0]              tag;
        mat_decd_pkg::mat_type_t mtype;
        logic [31:0]             opcode;
        mat_decd_pkg::alu_meta_t alu;
        mat_decd_pkg::lsu_meta_t lsu;
        mat_decd_pkg::cfg_meta_t cfg;
        logic                    illegal;
        logic [3:0]              idle;    // idle cycles before this case
    } test_case_t;

    logic                    cpuclk;
    logic                    arst_n;
    logic                    inst_vld;
    logic [31:0]             inst_opcode;
    mat_decd_pkg::mat_type_t inst_type;
    mat_decd_pkg::alu_meta_t alu_meta;
    mat_decd_pkg::lsu_meta_t lsu_meta;
    mat_decd_pkg::cfg_meta_t cfg_meta;
    logic                    meta_vld;
    logic                    decd_illegal;

    test_case_t              cases[$];
    test_case_t              pend;      // instruction driven in the previous cycle
    logic                    pending;
    logic                    cases_loaded;
    mat_decd_pkg::alu_meta_t held_alu;  // records kept between strobes
    mat_decd_pkg::lsu_meta_t held_lsu;
    mat_decd_pkg::cfg_meta_t held_cfg;

    mat_decd_stage dut_i (
        .cpuclk       (cpuclk),
        .arst_n       (arst_n),
        .inst_vld     (inst_vld),
        .inst_opcode  (inst_opcode),
        .inst_type    (inst_type),
        .alu_meta     (alu_meta),
        .lsu_meta     (lsu_meta),
        .cfg_meta     (cfg_meta),
        .meta_vld     (meta_vld),
        .decd_illegal (decd_illegal)
    );

    initial
    begin
        cpuclk = 1'b0;
        forever #(CLK_PERIOD / 2) cpuclk = ~cpuclk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        string       line;
        logic [31:0] col [0:7];
        test_case_t  tc;
        fd = $fopen("dv/mat_decd_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the cases file dv/mat_decd_cases.txt");
            $display("Errors found");
            $fatal(1, "no stimulus");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%h %h %h %h %h %h %h %h", col[0], col[1], col[2], col[3],
                            col[4], col[5], col[6], col[7]);
                if (n == 8) // comment and blank lines give fewer fields
                begin
                    tc.tag     = col[0][7:0];
                    tc.mtype   = col[1][3:0];
                    tc.opcode  = col[2];
                    tc.alu     = col[3][30:0];
                    tc.lsu     = col[4][15:0];
                    tc.cfg     = col[5][10:0];
                    tc.illegal = col[6][0];
                    tc.idle    = col[7][3:0];
                    cases.push_back(tc);
                end
            end
            $fclose(fd);
            if (cases.size() == 0)
            begin
                $display("the cases file holds no test lines");
                $display("Errors found");
                $fatal(1, "no stimulus");
            end
            else
                cases_loaded = 1'b1;
        end
    endtask

    // result of the previous cycle's instruction, or a held idle state
    task automatic check_outputs();
        string tag_name;
        logic  exp_ill;
        if (pending)
        begin
            tag_name = $sformatf("case %02h", pend.tag);
            held_alu = pend.alu;
            held_lsu = pend.lsu;
            held_cfg = pend.cfg;
            exp_ill  = pend.illegal;
        end
        else
        begin
            tag_name = "idle cycle";
            exp_ill  = 1'b0;
        end
        check_value({tag_name, " meta_vld"}, 32'(pending), 32'(meta_vld));
        check_value({tag_name, " decd_illegal"}, 32'(exp_ill), 32'(decd_illegal));
        check_value({tag_name, " alu_meta"}, 32'(held_alu), 32'(alu_meta));
        check_value({tag_name, " lsu_meta"}, 32'(held_lsu), 32'(lsu_meta));
        check_value({tag_name, " cfg_meta"}, 32'(held_cfg), 32'(cfg_meta));
    endtask

    task automatic drive_step(input logic vld, input test_case_t tc);
        @(negedge cpuclk);
        check_outputs();
        inst_vld = vld;
        if (vld)
        begin
            inst_type   = tc.mtype;
            inst_opcode = tc.opcode;
        end
        pending = vld;
        pend    = tc;
    endtask

    initial
    begin
        wait (cases_loaded);
        #(cases.size() * CASE_TIME + RESET_TIME);
        $display("watchdog expired, the run hung waiting for the DUT");
        $display("Errors found");
        $fatal(1, "timeout");
    end

    initial
    begin
        arst_n       = 1'b0;
        inst_vld     = 1'b0;
        inst_opcode  = '0;
        inst_type    = '0;
        pending      = 1'b0;
        pend         = '0;
        held_alu     = '0;
        held_lsu     = '0;
        held_cfg     = '0;
        cases_loaded = 1'b0;
        load_cases();
        repeat (RESET_CYCLES) drive_step(1'b0, '0);
        arst_n = 1'b1;
        repeat (2) drive_step(1'b0, '0); // records stay zero before the first instruction
        foreach (cases[i])
        begin
            repeat (cases[i].idle) drive_step(1'b0, '0);
            drive_step(1'b1, cases[i]);
        end
        repeat (2) drive_step(1'b0, '0); // last result, then a quiet cycle
        $display("No errors");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/mat_decd_pkg.sv
design/mat_cal_decoder.sv
design/mat_mem_cfg_decoder.sv
design/mat_meta_merge.sv
design/mat_decd_stage.sv
dv/tb_mat_decd.sv
